// ==== hw/isa_pkg.sv ====
package isa_pkg;

    ////////////////////////////////////////////////////////////
    // instruction set encodings
    ////////////////////////////////////////////////////////////

    // bit 3 set marks the immediate form of an alu op
    typedef enum logic [5:0] {
        ADD_R    = 6'h00,
        SUB_R    = 6'h01,
        AND_R    = 6'h02,
        OR_R     = 6'h03,
        XOR_R    = 6'h04,
        SHL_R    = 6'h05,
        SHR_R    = 6'h06,
        ADD_I    = 6'h08,
        SUB_I    = 6'h09,
        AND_I    = 6'h0a,
        OR_I     = 6'h0b,
        XOR_I    = 6'h0c,
        SHL_I    = 6'h0d,
        SHR_I    = 6'h0e,
        LOAD     = 6'h10,
        STORE    = 6'h11,
        PORT_OUT = 6'h12,
        NOP      = 6'h3f
    } opcode_e;

    // alu function selects
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SHL,
        ALU_SHR,
        ALU_PASS
    } alu_op_e;

    // memory command class
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE,
        MEM_PORT_OUT
    } mem_op_e;

    // fetched instruction word
    typedef struct packed {
        opcode_e    opcode;
        logic [9:0] operand;
    } instr_t;

endpackage

// ==== hw/ctrl_pkg.sv ====
package ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // stage state machines
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        F_IDLE,
        F_FETCH,
        F_DECODE,
        F_EXT,
        F_ISSUE
    } fetch_state_e;

    typedef enum logic [2:0] {
        M_IDLE,
        M_LOAD_REQ,
        M_LOAD_WAIT,
        M_STORE_REQ,
        M_PORT_RAISE,
        M_PORT_DROP
    } mem_state_e;

    ////////////////////////////////////////////////////////////
    // control words
    ////////////////////////////////////////////////////////////

    // execute control issued once per instruction
    typedef struct packed {
        isa_pkg::alu_op_e alu_op;
        logic             reg_write;
        logic             imm_sel;
        logic             trap;
    } exec_ctrl_t;

    // command handed from fetch to memory stage
    typedef struct packed {
        isa_pkg::mem_op_e op;
        logic             reg_write;
    } mem_cmd_t;

    // external data bus request
    typedef struct packed {
        logic d_req;
        logic d_we;
    } data_bus_t;

endpackage

// ==== hw/opcode_decoder.sv ====
`timescale 1ns/1ps

module opcode_decoder (
    input  isa_pkg::opcode_e     opcode,
    output ctrl_pkg::exec_ctrl_t exec_ctrl,
    output isa_pkg::mem_op_e     mem_op,
    output logic                 needs_ext
);

    always_comb
    begin
        // most opcodes write a register and touch no memory
        exec_ctrl.alu_op    = isa_pkg::ALU_PASS;
        exec_ctrl.reg_write = 1'b1;
        exec_ctrl.imm_sel   = 1'b0;
        exec_ctrl.trap      = 1'b0;
        mem_op              = isa_pkg::MEM_NONE;
        needs_ext           = 1'b0;

        case (opcode)
            isa_pkg::ADD_R, isa_pkg::ADD_I:
                exec_ctrl.alu_op = isa_pkg::ALU_ADD;
            isa_pkg::SUB_R, isa_pkg::SUB_I:
                exec_ctrl.alu_op = isa_pkg::ALU_SUB;
            isa_pkg::AND_R, isa_pkg::AND_I:
                exec_ctrl.alu_op = isa_pkg::ALU_AND;
            isa_pkg::OR_R, isa_pkg::OR_I:
                exec_ctrl.alu_op = isa_pkg::ALU_OR;
            isa_pkg::XOR_R, isa_pkg::XOR_I:
                exec_ctrl.alu_op = isa_pkg::ALU_XOR;
            isa_pkg::SHL_R, isa_pkg::SHL_I:
                exec_ctrl.alu_op = isa_pkg::ALU_SHL;
            isa_pkg::SHR_R, isa_pkg::SHR_I:
                exec_ctrl.alu_op = isa_pkg::ALU_SHR;
            isa_pkg::LOAD:
            begin
                // address is base plus operand
                exec_ctrl.alu_op = isa_pkg::ALU_ADD;
                mem_op           = isa_pkg::MEM_LOAD;
            end
            isa_pkg::STORE:
            begin
                exec_ctrl.alu_op    = isa_pkg::ALU_ADD;
                exec_ctrl.reg_write = 1'b0;
                mem_op              = isa_pkg::MEM_STORE;
            end
            isa_pkg::PORT_OUT:
            begin
                exec_ctrl.reg_write = 1'b0;
                mem_op              = isa_pkg::MEM_PORT_OUT;
            end
            isa_pkg::NOP:
                exec_ctrl.reg_write = 1'b0;
            default:
            begin
                // undefined opcode traps
                exec_ctrl.reg_write = 1'b0;
                exec_ctrl.trap      = 1'b1;
            end
        endcase

        // immediate forms carry a second word
        if (opcode inside {isa_pkg::ADD_I, isa_pkg::SUB_I, isa_pkg::AND_I, isa_pkg::OR_I,
                           isa_pkg::XOR_I, isa_pkg::SHL_I, isa_pkg::SHR_I})
        begin
            exec_ctrl.imm_sel = 1'b1;
            needs_ext         = 1'b1;
        end
    end

endmodule

// ==== hw/fetch_fsm.sv ====
`timescale 1ns/1ps

module fetch_fsm #(
    parameter int INSTR_W = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    input  isa_pkg::instr_t      instr,
    output logic                 fetch_req,
    output logic                 exec_valid,
    output ctrl_pkg::exec_ctrl_t exec_ctrl,
    output ctrl_pkg::mem_cmd_t   mem_cmd,
    output logic                 mem_valid,
    input  logic                 mem_ready
);

    ctrl_pkg::fetch_state_e state;
    ctrl_pkg::fetch_state_e state_nxt;
    logic [INSTR_W-1:0]     word_q;
    isa_pkg::instr_t        word;
    isa_pkg::mem_op_e       dec_mem_op;
    logic                   needs_ext;
    logic                   ext_done;
    logic                   ext_pending;

    assign word = isa_pkg::instr_t'(word_q);

    opcode_decoder i_decoder (
        .opcode    (word.opcode),
        .exec_ctrl (exec_ctrl),
        .mem_op    (dec_mem_op),
        .needs_ext (needs_ext)
    );

    ////////////////////////////////////////////////////////////
    // state register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= ctrl_pkg::F_IDLE;
            ext_done <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            // first word clears it, the extension word sets it
            if (fetch_req && instr_valid)
                ext_done <= (state != ctrl_pkg::F_FETCH);
        end
    end

    // opcode word, captured on the first acceptance only
    always_ff @(posedge clk)
    begin
        if (state == ctrl_pkg::F_FETCH && instr_valid)
            word_q <= instr;
    end

    ////////////////////////////////////////////////////////////
    // next state and outputs
    ////////////////////////////////////////////////////////////

    assign ext_pending = needs_ext && !ext_done;

    always_comb
    begin
        state_nxt = state;
        case (state)
            ctrl_pkg::F_IDLE:
                state_nxt = ctrl_pkg::F_FETCH;
            ctrl_pkg::F_FETCH:
                if (instr_valid)
                    state_nxt = ctrl_pkg::F_DECODE;
            ctrl_pkg::F_DECODE:
                if (!ext_pending)
                    state_nxt = ctrl_pkg::F_ISSUE;
                else if (!instr_valid)
                    state_nxt = ctrl_pkg::F_EXT;
            ctrl_pkg::F_EXT:
                if (instr_valid)
                    state_nxt = ctrl_pkg::F_DECODE;
            ctrl_pkg::F_ISSUE:
                if (!mem_valid || mem_ready)
                    state_nxt = ctrl_pkg::F_IDLE;
            default:
                state_nxt = ctrl_pkg::F_IDLE;
        endcase
    end

    // extension request already goes out while decoding
    assign fetch_req = (state == ctrl_pkg::F_FETCH) || (state == ctrl_pkg::F_EXT) ||
                       (state == ctrl_pkg::F_DECODE && ext_pending);

    assign mem_valid  = (state == ctrl_pkg::F_ISSUE) && (dec_mem_op != isa_pkg::MEM_NONE);
    // memory ops issue together with the command transfer
    assign exec_valid = (state == ctrl_pkg::F_ISSUE) && (!mem_valid || mem_ready);

    assign mem_cmd.op        = dec_mem_op;
    assign mem_cmd.reg_write = exec_ctrl.reg_write;

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // fetch request held until a word arrives
    assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req && !instr_valid |=> fetch_req);

    assert property (@(posedge clk) $bits(isa_pkg::instr_t) == INSTR_W);

endmodule

// ==== hw/mem_fsm.sv ====
`timescale 1ns/1ps

module mem_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ctrl_pkg::mem_cmd_t   mem_cmd,
    input  logic                 mem_valid,
    output logic                 mem_ready,
    output ctrl_pkg::data_bus_t  data_bus,
    input  logic                 d_ready,
    input  logic                 d_rvalid,
    output logic                 port_strobe,
    input  logic                 port_ack,
    output logic                 mem_wb_valid
);

    ctrl_pkg::mem_state_e state;
    ctrl_pkg::mem_state_e state_nxt;
    logic                 wb_en_q;

    ////////////////////////////////////////////////////////////
    // state register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state        <= ctrl_pkg::M_IDLE;
            mem_wb_valid <= 1'b0;
        end
        else
        begin
            state        <= state_nxt;
            // write-back one cycle after read data returns
            mem_wb_valid <= (state == ctrl_pkg::M_LOAD_WAIT) && d_rvalid && wb_en_q;
        end
    end

    // write-back enable of the command in flight
    always_ff @(posedge clk)
    begin
        if (mem_valid && mem_ready)
            wb_en_q <= mem_cmd.reg_write;
    end

    ////////////////////////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            ctrl_pkg::M_IDLE:
                if (mem_valid)
                begin
                    case (mem_cmd.op)
                        isa_pkg::MEM_LOAD:     state_nxt = ctrl_pkg::M_LOAD_REQ;
                        isa_pkg::MEM_STORE:    state_nxt = ctrl_pkg::M_STORE_REQ;
                        isa_pkg::MEM_PORT_OUT: state_nxt = ctrl_pkg::M_PORT_RAISE;
                        default:               state_nxt = ctrl_pkg::M_IDLE;
                    endcase
                end
            ctrl_pkg::M_LOAD_REQ:
                if (d_ready)
                    state_nxt = ctrl_pkg::M_LOAD_WAIT;
            ctrl_pkg::M_LOAD_WAIT:
                if (d_rvalid)
                    state_nxt = ctrl_pkg::M_IDLE;
            ctrl_pkg::M_STORE_REQ:
                if (d_ready)
                    state_nxt = ctrl_pkg::M_IDLE;
            // four-phase port handshake
            ctrl_pkg::M_PORT_RAISE:
                if (port_ack)
                    state_nxt = ctrl_pkg::M_PORT_DROP;
            ctrl_pkg::M_PORT_DROP:
                if (!port_ack)
                    state_nxt = ctrl_pkg::M_IDLE;
            default:
                state_nxt = ctrl_pkg::M_IDLE;
        endcase
    end

    assign mem_ready      = (state == ctrl_pkg::M_IDLE);
    assign data_bus.d_req = (state == ctrl_pkg::M_LOAD_REQ) || (state == ctrl_pkg::M_STORE_REQ);
    assign data_bus.d_we  = (state == ctrl_pkg::M_STORE_REQ);
    assign port_strobe    = (state == ctrl_pkg::M_PORT_RAISE);

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // request and direction hold until the bus takes them
    assert property (@(posedge clk) disable iff (!rst_n)
        data_bus.d_req && !d_ready |=> data_bus.d_req && $stable(data_bus));

    // strobe held until acknowledged
    assert property (@(posedge clk) disable iff (!rst_n)
        port_strobe && !port_ack |=> port_strobe);

endmodule

// ==== hw/seq_controller.sv ====
`timescale 1ns/1ps

module seq_controller #(
    parameter int INSTR_W = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 fetch_req,
    input  logic                 instr_valid,
    input  isa_pkg::instr_t      instr,
    output logic                 exec_valid,
    output ctrl_pkg::exec_ctrl_t exec_ctrl,
    output ctrl_pkg::data_bus_t  data_bus,
    input  logic                 d_ready,
    input  logic                 d_rvalid,
    output logic                 port_strobe,
    input  logic                 port_ack,
    output logic                 mem_wb_valid
);

    // fetch to memory stage handoff
    ctrl_pkg::mem_cmd_t mem_cmd;
    logic               mem_valid;
    logic               mem_ready;

    fetch_fsm #(
        .INSTR_W (INSTR_W)
    ) i_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .fetch_req   (fetch_req),
        .exec_valid  (exec_valid),
        .exec_ctrl   (exec_ctrl),
        .mem_cmd     (mem_cmd),
        .mem_valid   (mem_valid),
        .mem_ready   (mem_ready)
    );

    mem_fsm i_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_cmd      (mem_cmd),
        .mem_valid    (mem_valid),
        .mem_ready    (mem_ready),
        .data_bus     (data_bus),
        .d_ready      (d_ready),
        .d_rvalid     (d_rvalid),
        .port_strobe  (port_strobe),
        .port_ack     (port_ack),
        .mem_wb_valid (mem_wb_valid)
    );

endmodule

// ==== verif/tb_seq_controller.sv ====
`timescale 1ns/1ps

module tb_seq_controller;

    logic                 clk;
    logic                 rst_n;
    logic                 fetch_req;
    logic                 instr_valid;
    isa_pkg::instr_t      instr;
    logic                 exec_valid;
    ctrl_pkg::exec_ctrl_t exec_ctrl;
    ctrl_pkg::data_bus_t  data_bus;
    logic                 d_ready;
    logic                 d_rvalid;
    logic                 port_strobe;
    logic                 port_ack;
    logic                 mem_wb_valid;

    // test table from the data file
    string                t_name[$];
    isa_pkg::opcode_e     t_op[$];
    ctrl_pkg::exec_ctrl_t t_exec[$];
    isa_pkg::mem_op_e     t_mem[$];

    // memory commands issued and not yet completed
    string                pend_name[$];
    isa_pkg::mem_op_e     pend_op[$];

    integer               seed = 32'h73e3_67af;
    int                   n_tests = 0;
    logic                 loaded = 1'b0;
    int                   cycle = 0;
    int                   acc_count = 0;
    int                   last_acc = 0;
    // first cycle the memory stage can take a new command
    int                   mem_free = 0;
    int                   exp_issue = 0;
    int                   i_wait = 0;
    int                   d_wait = 0;
    int                   rv_wait = 0;
    int                   p_wait = 0;
    logic                 rv_armed = 1'b0;
    logic                 load_pend = 1'b0;
    logic                 ack_seen = 1'b0;
    logic                 strobe_q = 1'b0;
    logic                 fetch_on = 1'b1;
    logic                 rst_nxt = 1'b0;
    logic                 iv_nxt = 1'b0;
    logic                 dr_nxt = 1'b0;
    logic                 rv_nxt = 1'b0;
    logic                 pa_nxt = 1'b0;
    isa_pkg::instr_t      word_nxt = '0;

    seq_controller #(
        .INSTR_W (16)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_req    (fetch_req),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .exec_valid   (exec_valid),
        .exec_ctrl    (exec_ctrl),
        .data_bus     (data_bus),
        .d_ready      (d_ready),
        .d_rvalid     (d_rvalid),
        .port_strobe  (port_strobe),
        .port_ack     (port_ack),
        .mem_wb_valid (mem_wb_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // reporting and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic fail_run();
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic string exec_str(ctrl_pkg::exec_ctrl_t c);
        return $sformatf("alu=%0d we=%0b imm=%0b trap=%0b",
                         c.alu_op, c.reg_write, c.imm_sel, c.trap);
    endfunction

    task automatic check_exec(string name, ctrl_pkg::exec_ctrl_t exp, ctrl_pkg::exec_ctrl_t act);
        if (exp !== act)
        begin
            $display("[ERROR] %s: exec_ctrl expected %s actual %s",
                     name, exec_str(exp), exec_str(act));
            fail_run();
        end
    endtask

    task automatic check_mem(string name, isa_pkg::mem_op_e exp, isa_pkg::mem_op_e act);
        if (exp !== act)
        begin
            $display("[ERROR] %s: memory op expected %s actual %s",
                     name, exp.name(), act.name());
            fail_run();
        end
    endtask

    task automatic check_count(string name, string what, int exp, int act);
        if (exp != act)
        begin
            $display("[ERROR] %s: %s expected %0d actual %0d", name, what, exp, act);
            fail_run();
        end
    endtask

    function automatic int random_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    function automatic logic mem_busy();
        return data_bus.d_req || load_pend || port_strobe || port_ack;
    endfunction

    // completed access is matched against the oldest issued command
    task automatic mem_done(isa_pkg::mem_op_e op);
        if (pend_name.size() == 0)
        begin
            $display("memory or port access seen with no memory command issued");
            fail_run();
        end
        check_mem(pend_name.pop_front(), pend_op.pop_front(), op);
    endtask

    ////////////////////////////////////////////////////////////
    // instruction, data bus and port models
    ////////////////////////////////////////////////////////////

    task automatic run_models();
        if (fetch_req && instr_valid)
        begin
            acc_count++;
            last_acc = cycle;
            iv_nxt   = 1'b0;
            i_wait   = random_delay();
            // extension word is arbitrary data
            word_nxt = isa_pkg::instr_t'($random(seed));
        end
        else if (fetch_req && fetch_on)
        begin
            if (i_wait == 0)
                iv_nxt = 1'b1;
            else
                i_wait--;
        end

        if (mem_wb_valid)
        begin
            if (!load_pend)
            begin
                $display("write-back pulse without a pending load");
                fail_run();
            end
            load_pend = 1'b0;
            // stage is back in idle while the pulse is out
            mem_free  = cycle;
            mem_done(isa_pkg::MEM_LOAD);
        end
        if (data_bus.d_req && d_ready)
        begin
            dr_nxt = 1'b0;
            d_wait = random_delay();
            if (data_bus.d_we)
            begin
                mem_free = cycle + 1;
                mem_done(isa_pkg::MEM_STORE);
            end
            else if (load_pend)
            begin
                $display("second data request accepted while a load was pending");
                fail_run();
            end
            else
            begin
                load_pend = 1'b1;
                rv_armed  = 1'b1;
                rv_wait   = random_delay();
            end
        end
        else if (data_bus.d_req)
        begin
            if (d_wait == 0)
                dr_nxt = 1'b1;
            else
                d_wait--;
        end
        if (d_rvalid)
            rv_nxt = 1'b0;
        else if (rv_armed)
        begin
            if (rv_wait == 0)
            begin
                rv_nxt   = 1'b1;
                rv_armed = 1'b0;
            end
            else
                rv_wait--;
        end

        // four-phase port
        if (port_strobe && port_ack)
            ack_seen = 1'b1;
        if (strobe_q && !port_strobe)
        begin
            if (!ack_seen)
            begin
                $display("port_strobe dropped before port_ack was seen");
                fail_run();
            end
            ack_seen = 1'b0;
            mem_done(isa_pkg::MEM_PORT_OUT);
        end
        strobe_q = port_strobe;
        if (port_strobe != port_ack)
        begin
            if (p_wait == 0)
            begin
                pa_nxt = port_strobe;
                // ack falls next cycle, idle the cycle after
                if (!port_strobe)
                    mem_free = cycle + 2;
                p_wait = random_delay();
            end
            else
                p_wait--;
        end
    endtask

    // drive just after the edge, sample mid cycle
    task automatic tick();
        @(posedge clk);
        #10;
        rst_n       = rst_nxt;
        instr_valid = iv_nxt;
        instr       = word_nxt;
        d_ready     = dr_nxt;
        d_rvalid    = rv_nxt;
        port_ack    = pa_nxt;
        @(negedge clk);
        cycle++;
        run_models();
    endtask

    ////////////////////////////////////////////////////////////
    // test file reader
    ////////////////////////////////////////////////////////////

    task automatic read_tests();
        int                   fd;
        int                   r;
        string                tok;
        logic [8*200-1:0]     junk;
        logic [5:0]           op;
        int                   alu;
        int                   we;
        int                   imm;
        int                   trap;
        int                   mop;
        ctrl_pkg::exec_ctrl_t e;

        fd = $fopen("verif/controller_tests.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open verif/controller_tests.txt");
            fail_run();
        end
        while (!$feof(fd))
        begin
            r = $fscanf(fd, "%s", tok);
            if (r != 1)
                break;
            if (tok[0] == "#")
            begin
                r = $fgets(junk, fd);
                continue;
            end
            r = $fscanf(fd, "%h %d %d %d %d %d", op, alu, we, imm, trap, mop);
            if (r != 6)
            begin
                $display("malformed line in test file after %s", tok);
                fail_run();
            end
            e.alu_op    = isa_pkg::alu_op_e'(alu[2:0]);
            e.reg_write = we[0];
            e.imm_sel   = imm[0];
            e.trap      = trap[0];
            t_name.push_back(tok);
            t_op.push_back(isa_pkg::opcode_e'(op));
            t_exec.push_back(e);
            t_mem.push_back(isa_pkg::mem_op_e'(mop[1:0]));
        end
        $fclose(fd);
        n_tests = t_name.size();
    endtask

    initial
    begin
        wait (loaded);
        repeat (n_tests * 40 + 20) @(posedge clk);
        $display("watchdog expired before all tests finished");
        fail_run();
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        d_ready     = 1'b0;
        d_rvalid    = 1'b0;
        port_ack    = 1'b0;
        read_tests();
        loaded   = 1'b1;
        word_nxt = {t_op[0], 10'h0a5};

        repeat (3)
        begin
            tick();
            if (fetch_req || exec_valid || mem_wb_valid || data_bus.d_req ||
                data_bus.d_we || port_strobe)
            begin
                $display("control output high during reset");
                fail_run();
            end
        end
        rst_nxt = 1'b1;
        tick();
        tick();
        if (!fetch_req)
        begin
            $display("fetch_req did not rise after reset release");
            fail_run();
        end

        for (int i = 0; i < n_tests; i++)
        begin
            while (!exec_valid)
                tick();
            check_count(t_name[i], "fetch acceptances", t_exec[i].imm_sel ? 2 : 1, acc_count);
            check_exec(t_name[i], t_exec[i], exec_ctrl);
            if (t_mem[i] != isa_pkg::MEM_NONE)
            begin
                if (mem_busy() || pend_name.size() != 0)
                begin
                    $display("%s issued before the previous memory access completed",
                             t_name[i]);
                    fail_run();
                end
                // two cycles after acceptance unless the memory stage is still busy
                exp_issue = (mem_free > last_acc + 2) ? mem_free : last_acc + 2;
                check_count(t_name[i], "issue cycle", exp_issue, cycle);
                pend_name.push_back(t_name[i]);
                pend_op.push_back(t_mem[i]);
            end
            else
                check_count(t_name[i], "issue delay", 2, cycle - last_acc);
            acc_count = 0;
            if (i + 1 < n_tests)
                word_nxt = {t_op[i + 1], 10'h0a5};
            else
                fetch_on = 1'b0;
            tick();
        end

        // let the last accesses finish
        while (pend_name.size() != 0 || mem_busy())
            tick();
        repeat (4) tick();

        if (!port_strobe && !data_bus.d_req)
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
        begin
            $display("memory stage not idle at end of run");
            fail_run();
        end
    end

endmodule

// ==== verif/controller_tests.txt ====
# name opcode(hex) alu_op reg_write imm_sel trap mem_op
# alu_op 0 add 1 sub 2 and 3 or 4 xor 5 shl 6 shr 7 pass, mem_op 0 none 1 load 2 store 3 port
add_r    00 0 1 0 0 0
sub_r    01 1 1 0 0 0
and_r    02 2 1 0 0 0
or_r     03 3 1 0 0 0
xor_r    04 4 1 0 0 0
shl_r    05 5 1 0 0 0
shr_r    06 6 1 0 0 0
nop      3f 7 0 0 0 0
add_i    08 0 1 1 0 0
sub_i    09 1 1 1 0 0
and_i    0a 2 1 1 0 0
or_i     0b 3 1 1 0 0
xor_i    0c 4 1 1 0 0
shl_i    0d 5 1 1 0 0
shr_i    0e 6 1 1 0 0
load     10 0 1 0 0 1
store    11 0 0 0 0 2
port_out 12 7 0 0 0 3
ill_07   07 7 0 0 1 0
ill_0f   0f 7 0 0 1 0
ill_13   13 7 0 0 1 0
ill_20   20 7 0 0 1 0
b2b_ld0  10 0 1 0 0 1
b2b_ld1  10 0 1 0 0 1
b2b_st0  11 0 0 0 0 2
b2b_pt0  12 7 0 0 0 3
b2b_pt1  12 7 0 0 0 3
b2b_st1  11 0 0 0 0 2
b2b_ld2  10 0 1 0 0 1
tail_add 00 0 1 0 0 0

// ==== verilog.f ====
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/opcode_decoder.sv
hw/fetch_fsm.sv
hw/mem_fsm.sv
hw/seq_controller.sv
verif/tb_seq_controller.sv
